// ==== source/trap_cause_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Exception codes watched by the trap return address monitor, and the
// slot that each cause occupies in every per-cause vector
// Slot order is also the retirement priority order, highest first
// Only synchronous exceptions are covered; interrupts never own a slot
////////////////////////////////////////////////////////////////////////////

package trap_cause_pkg;

  // Number of monitored exception causes
  localparam int unsigned N_CAUSES = 5;

  // Slot index of each cause
  // Lower index wins when one retirement raises several causes
  localparam int unsigned SLOT_MPU     = 0;
  localparam int unsigned SLOT_BUS     = 1;
  localparam int unsigned SLOT_ILLEGAL = 2;
  localparam int unsigned SLOT_ECALL   = 3;
  localparam int unsigned SLOT_EBREAK  = 4;

  // Exception code field of mcause as presented on a cause save
  typedef logic [10:0] cause_code_t;

  // Architectural codes, bus fault uses the custom code of the core
  localparam cause_code_t CAUSE_INSTR_FAULT     = 11'h001;
  localparam cause_code_t CAUSE_ILLEGAL_INSN    = 11'h002;
  localparam cause_code_t CAUSE_BREAKPOINT      = 11'h003;
  localparam cause_code_t CAUSE_ECALL_MMODE     = 11'h00B;
  localparam cause_code_t CAUSE_INSTR_BUS_FAULT = 11'h018;

  // Code that a cause save must carry to land in each slot
  // Entries must stay distinct, otherwise one save would hit two slots
  localparam cause_code_t SLOT_CAUSE [N_CAUSES] = '{
    CAUSE_INSTR_FAULT,
    CAUSE_INSTR_BUS_FAULT,
    CAUSE_ILLEGAL_INSN,
    CAUSE_ECALL_MMODE,
    CAUSE_BREAKPOINT
  };

endpackage

// ==== source/monitor_types_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Types shared by the blocks of the trap return address monitor
// Vector width follows the cause count in the cause package, so that
// package has to be compiled first
////////////////////////////////////////////////////////////////////////////

package monitor_types_pkg;

  // One bit per monitored cause, indexed by slot number
  typedef logic [trap_cause_pkg::N_CAUSES-1:0] cause_vec_t;

  // Progress of one cause slot
  // WAIT     nothing captured yet
  // GOT_EXP  trapping PC captured, still waiting for the mepc write
  // GOT_ACT  mepc write captured, still waiting for the retirement
  // DECIDED  both sides captured and compared, held until reset
  typedef enum logic [1:0] {
    SLOT_WAIT    = 2'b00,
    SLOT_GOT_EXP = 2'b01,
    SLOT_GOT_ACT = 2'b10,
    SLOT_DECIDED = 2'b11
  } slot_state_e;

endpackage

// ==== source/trap_slot_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Per-cause link between the classifier, one cause slot and the
// collector
// Strobes are single-cycle and sampled on the rising clock edge
// There is no handshake, a slot takes a strobe in every cycle
////////////////////////////////////////////////////////////////////////////

interface trap_slot_if #(
  parameter int unsigned PC_W = 32
);

  // Retirement that should trap with this slot's cause
  logic            exp_valid;
  logic [PC_W-1:0] exp_pc;

  // Cause save carrying this slot's code, with the mepc being written
  logic            act_valid;
  logic [PC_W-1:0] act_mepc;

  // Verdict levels, match only means something while done is high
  logic            done;
  logic            match;

  modport feeder (
    output exp_valid, exp_pc, act_valid, act_mepc
  );

  modport slot (
    input  exp_valid, exp_pc, act_valid, act_mepc,
    output done, match
  );

  modport drain (
    input done, match
  );

endinterface

// ==== source/retire_classifier.sv ====
////////////////////////////////////////////////////////////////////////////
// Turns writeback retirements and cause saves into per-slot strobes
// Purely combinational, the strobes appear in the cycle of the inputs
// clk and rst_ni only clock the built-in check
// At most one cause is picked per retirement; a retirement is dropped
// while an interrupt, debug request or NMI is being taken
////////////////////////////////////////////////////////////////////////////

module retire_classifier #(
  parameter int unsigned PC_W = 32
) (
  input  logic                        clk,
  input  logic                        rst_ni,

  // Instruction retiring at writeback and its exception flags
  input  logic                        retire_valid,
  input  logic [PC_W-1:0]             retire_pc,
  input  logic                        retire_illegal,
  input  logic                        retire_ecall,
  input  logic                        retire_ebreak,
  input  logic                        retire_bus_err,
  input  logic                        retire_mpu_err,

  // Events that take precedence over a synchronous exception
  input  logic                        irq_ack,
  input  logic                        debug_req,
  input  logic                        nmi_pending,
  input  logic                        debug_entry,

  // Cause save strobe of the CSR block
  input  logic                        csr_save_cause,
  input  logic                        cause_interrupt,
  input  trap_cause_pkg::cause_code_t cause_code,
  input  logic [PC_W-1:0]             mepc_next,

  trap_slot_if.feeder                 slots [trap_cause_pkg::N_CAUSES]
);

  monitor_types_pkg::cause_vec_t raw_flags;
  monitor_types_pkg::cause_vec_t pick;
  monitor_types_pkg::cause_vec_t exp_sel;
  monitor_types_pkg::cause_vec_t act_sel;
  logic                          retire_ok;
  logic                          exc_ok;
  logic                          save_ok;

  //////////////////////////////////////////////////////////////////////////
  // Expected side
  //////////////////////////////////////////////////////////////////////////

  // Gather the flags in slot order so that the lowest set bit is the winner
  always_comb begin
    raw_flags                               = '0;
    raw_flags[trap_cause_pkg::SLOT_MPU]     = retire_mpu_err;
    raw_flags[trap_cause_pkg::SLOT_BUS]     = retire_bus_err;
    raw_flags[trap_cause_pkg::SLOT_ILLEGAL] = retire_illegal;
    raw_flags[trap_cause_pkg::SLOT_ECALL]   = retire_ecall;
    raw_flags[trap_cause_pkg::SLOT_EBREAK]  = retire_ebreak;
  end

  // Isolate the lowest set bit, which is the highest priority cause
  assign pick = raw_flags & (~raw_flags + monitor_types_pkg::cause_vec_t'(1));

  // Interrupt ack, taken debug request and pending NMI all win over a trap
  assign retire_ok = retire_valid && !irq_ack && !debug_req && !nmi_pending;

  // Debug entry suppresses everything except EBREAK
  assign exc_ok = retire_ok && !debug_entry;

  always_comb begin
    exp_sel                              = exc_ok ? pick : '0;
    exp_sel[trap_cause_pkg::SLOT_EBREAK] = pick[trap_cause_pkg::SLOT_EBREAK] && retire_ok;
  end

  //////////////////////////////////////////////////////////////////////////
  // Actual side and slot drive
  //////////////////////////////////////////////////////////////////////////

  // Saves made for an interrupt carry no exception mepc
  assign save_ok = csr_save_cause && !cause_interrupt;

  for (genvar g = 0; g < trap_cause_pkg::N_CAUSES; g++) begin : gen_feed
    assign act_sel[g] = save_ok && (cause_code == trap_cause_pkg::SLOT_CAUSE[g]);

    // Values go to every slot, the strobes pick the one that captures
    assign slots[g].exp_valid = exp_sel[g];
    assign slots[g].exp_pc    = retire_pc;
    assign slots[g].act_valid = act_sel[g];
    assign slots[g].act_mepc  = mepc_next;
  end

  // Priority pick and the distinct codes of the slot table together keep
  // every strobe vector one-hot, so no event is ever counted twice
  a_one_strobe_per_side : assert property (
    @(posedge clk) disable iff (!rst_ni)
    $onehot0(exp_sel) && $onehot0(act_sel)
  );

endmodule

// ==== source/cause_slot.sv ====
////////////////////////////////////////////////////////////////////////////
// First-occurrence capture and compare for one exception cause
// Only the first strobe of each side is kept, later ones are ignored
// until reset; the verdict is final once done rises
// done and match go high one cycle after the second capture
////////////////////////////////////////////////////////////////////////////

module cause_slot #(
  parameter int unsigned PC_W = 32
) (
  input logic       clk,
  input logic       rst_ni,
  trap_slot_if.slot slot
);

  monitor_types_pkg::slot_state_e state_q;
  monitor_types_pkg::slot_state_e state_d;
  logic [PC_W-1:0]                exp_pc_q;
  logic [PC_W-1:0]                act_mepc_q;
  logic [PC_W-1:0]                cmp_exp;
  logic [PC_W-1:0]                cmp_act;
  logic                           have_exp;
  logic                           have_act;
  logic                           take_exp;
  logic                           take_act;
  logic                           match_q;

  // Which sides are already held
  assign have_exp = (state_q == monitor_types_pkg::SLOT_GOT_EXP) ||
                    (state_q == monitor_types_pkg::SLOT_DECIDED);
  assign have_act = (state_q == monitor_types_pkg::SLOT_GOT_ACT) ||
                    (state_q == monitor_types_pkg::SLOT_DECIDED);

  // A strobe is only taken while its side is still empty
  assign take_exp = slot.exp_valid && !have_exp;
  assign take_act = slot.act_valid && !have_act;

  //////////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      monitor_types_pkg::SLOT_WAIT: begin
        if (take_exp && take_act) begin
          state_d = monitor_types_pkg::SLOT_DECIDED;
        end else if (take_exp) begin
          state_d = monitor_types_pkg::SLOT_GOT_EXP;
        end else if (take_act) begin
          state_d = monitor_types_pkg::SLOT_GOT_ACT;
        end
      end
      monitor_types_pkg::SLOT_GOT_EXP: begin
        if (take_act) begin
          state_d = monitor_types_pkg::SLOT_DECIDED;
        end
      end
      monitor_types_pkg::SLOT_GOT_ACT: begin
        if (take_exp) begin
          state_d = monitor_types_pkg::SLOT_DECIDED;
        end
      end
      // Decided is terminal until reset
      default: state_d = state_q;
    endcase
  end

  // The value arriving this cycle counts as captured for the compare
  assign cmp_exp = take_exp ? slot.exp_pc : exp_pc_q;
  assign cmp_act = take_act ? slot.act_mepc : act_mepc_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= monitor_types_pkg::SLOT_WAIT;
      match_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Compare once, on the edge that enters the decided state
      if ((state_d == monitor_types_pkg::SLOT_DECIDED) &&
          (state_q != monitor_types_pkg::SLOT_DECIDED)) begin
        match_q <= (cmp_exp == cmp_act);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_exp) begin
      exp_pc_q <= slot.exp_pc;
    end
    if (take_act) begin
      act_mepc_q <= slot.act_mepc;
    end
  end

  assign slot.done  = (state_q == monitor_types_pkg::SLOT_DECIDED);
  assign slot.match = match_q;

  // The collector counts each decision once, so it must never be revised
  a_verdict_sticky : assert property (
    @(posedge clk) disable iff (!rst_ni)
    slot.done |=> slot.done && $stable(slot.match)
  );

endmodule

// ==== source/verdict_collector.sv ====
////////////////////////////////////////////////////////////////////////////
// Collects the slot verdicts into vectors, pulses on each new mismatch
// The pulse and the count update one cycle after a slot's done rises
// with match low; error_count saturates at its maximum value
////////////////////////////////////////////////////////////////////////////

module verdict_collector #(
  parameter int unsigned ERR_CNT_W = 4
) (
  input  logic                          clk,
  input  logic                          rst_ni,
  trap_slot_if.drain                    slots [trap_cause_pkg::N_CAUSES],
  output monitor_types_pkg::cause_vec_t cause_done,
  output monitor_types_pkg::cause_vec_t cause_match,
  output logic                          mismatch_pulse,
  output logic [ERR_CNT_W-1:0]          error_count
);

  // Width of the per-cycle mismatch count and of the unclipped sum
  localparam int unsigned NB_W  = $clog2(trap_cause_pkg::N_CAUSES + 1);
  localparam int unsigned SUM_W = ERR_CNT_W + NB_W;

  monitor_types_pkg::cause_vec_t done_q;
  monitor_types_pkg::cause_vec_t new_bad;
  logic [NB_W-1:0]               bad_cnt;
  logic [SUM_W-1:0]              sum;
  logic                          any_new_bad;

  for (genvar g = 0; g < trap_cause_pkg::N_CAUSES; g++) begin : gen_drain
    assign cause_done[g]  = slots[g].done;
    assign cause_match[g] = slots[g].match;
  end

  // A decision is new in the first cycle its done bit is seen high
  assign new_bad     = cause_done & ~done_q & ~cause_match;
  assign any_new_bad = |new_bad;

  always_comb begin
    bad_cnt = '0;
    for (int i = 0; i < trap_cause_pkg::N_CAUSES; i++) begin
      bad_cnt = bad_cnt + NB_W'(new_bad[i]);
    end
  end

  assign sum = SUM_W'(error_count) + SUM_W'(bad_cnt);

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q         <= '0;
      mismatch_pulse <= 1'b0;
      error_count    <= '0;
    end else begin
      done_q         <= cause_done;
      mismatch_pulse <= any_new_bad;
      // Clip at all ones rather than wrap
      if (sum > SUM_W'({ERR_CNT_W{1'b1}})) begin
        error_count <= '1;
      end else begin
        error_count <= sum[ERR_CNT_W-1:0];
      end
    end
  end

  // Back-to-back pulses need a newly decided mismatching slot in both earlier cycles
  a_pulse_needs_new_bad : assert property (
    @(posedge clk) disable iff (!rst_ni)
    mismatch_pulse && $past(mismatch_pulse) |->
      (|($past(cause_done) & ~$past(cause_match) & ~$past(cause_done, 2))) &&
      (|($past(cause_done, 2) & ~$past(cause_match, 2) & ~$past(cause_done, 3)))
  );

endmodule

// ==== source/trap_mepc_monitor.sv ====
////////////////////////////////////////////////////////////////////////////
// Trap return address monitor, checks for each synchronous exception
// cause that the first mepc written equals the PC of the first
// retirement that should trap with that cause
// Only the first pair per cause is judged, rst_ni rearms all slots
// cause_done follows the second capture by one cycle, mismatch_pulse
// by two; PC_W may be 32 or 64
////////////////////////////////////////////////////////////////////////////

module trap_mepc_monitor #(
  parameter int unsigned PC_W      = 32,
  parameter int unsigned ERR_CNT_W = 4
) (
  input  logic                          clk,
  input  logic                          rst_ni,

  // Writeback retirement
  input  logic                          retire_valid,
  input  logic [PC_W-1:0]               retire_pc,
  input  logic                          retire_illegal,
  input  logic                          retire_ecall,
  input  logic                          retire_ebreak,
  input  logic                          retire_bus_err,
  input  logic                          retire_mpu_err,

  // Higher priority events
  input  logic                          irq_ack,
  input  logic                          debug_req,
  input  logic                          nmi_pending,
  input  logic                          debug_entry,

  // Cause save from the CSR block
  input  logic                          csr_save_cause,
  input  logic                          cause_interrupt,
  input  trap_cause_pkg::cause_code_t   cause_code,
  input  logic [PC_W-1:0]               mepc_next,

  // Verdicts
  output monitor_types_pkg::cause_vec_t cause_done,
  output monitor_types_pkg::cause_vec_t cause_match,
  output logic                          mismatch_pulse,
  output logic [ERR_CNT_W-1:0]          error_count
);

  // One link per cause slot
  trap_slot_if #(.PC_W(PC_W)) slot_bus [trap_cause_pkg::N_CAUSES] ();

  retire_classifier #(
    .PC_W (PC_W)
  ) classifier_i (
    .clk             (clk),
    .rst_ni          (rst_ni),
    .retire_valid    (retire_valid),
    .retire_pc       (retire_pc),
    .retire_illegal  (retire_illegal),
    .retire_ecall    (retire_ecall),
    .retire_ebreak   (retire_ebreak),
    .retire_bus_err  (retire_bus_err),
    .retire_mpu_err  (retire_mpu_err),
    .irq_ack         (irq_ack),
    .debug_req       (debug_req),
    .nmi_pending     (nmi_pending),
    .debug_entry     (debug_entry),
    .csr_save_cause  (csr_save_cause),
    .cause_interrupt (cause_interrupt),
    .cause_code      (cause_code),
    .mepc_next       (mepc_next),
    .slots           (slot_bus)
  );

  // Slot g judges the cause at slot index g of the cause package
  for (genvar g = 0; g < trap_cause_pkg::N_CAUSES; g++) begin : gen_slot
    cause_slot #(
      .PC_W (PC_W)
    ) slot_i (
      .clk    (clk),
      .rst_ni (rst_ni),
      .slot   (slot_bus[g])
    );
  end

  verdict_collector #(
    .ERR_CNT_W (ERR_CNT_W)
  ) collector_i (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .slots          (slot_bus),
    .cause_done     (cause_done),
    .cause_match    (cause_match),
    .mismatch_pulse (mismatch_pulse),
    .error_count    (error_count)
  );

endmodule

// ==== verif/tb_tests.svh ====
////////////////////////////////////////////////////////////////////////////
// Directed tests, included inside the testbench module
// Each test starts from a fresh reset and leaves the inputs idle
////////////////////////////////////////////////////////////////////////////

`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

  task automatic test_after_reset();
    int unsigned start_err;
    start_err = errors;
    apply_reset();
    check_outputs('0, '0, 1'b0, 0);
    // Idle inputs must never produce a verdict
    repeat (20) begin
      step();
      check_outputs('0, '0, 1'b0, 0);
    end
    finish_test("outputs after reset", start_err);
  endtask

  task automatic test_illegal_match();
    logic [PC_W-1:0]               pc;
    monitor_types_pkg::cause_vec_t il;
    int unsigned                   start_err;
    start_err = errors;
    apply_reset();
    pc = $urandom();
    il = slot_bit(trap_cause_pkg::SLOT_ILLEGAL);
    retire(il, pc);
    check_outputs('0, '0, 1'b0, 0);
    // Verdict is visible in the cycle right after the save
    save_cause(trap_cause_pkg::CAUSE_ILLEGAL_INSN, pc);
    check_outputs(il, il, 1'b0, 0);
    repeat (3) begin
      step();
      check_outputs(il, il, 1'b0, 0);
    end
    finish_test("illegal trap with matching mepc", start_err);
  endtask

  task automatic test_ecall_mismatch();
    logic [PC_W-1:0]               pc;
    monitor_types_pkg::cause_vec_t ec;
    int unsigned                   start_err;
    start_err = errors;
    apply_reset();
    pc = $urandom();
    ec = slot_bit(trap_cause_pkg::SLOT_ECALL);
    save_cause(trap_cause_pkg::CAUSE_ECALL_MMODE, pc ^ PC_W'('h10));
    check_outputs('0, '0, 1'b0, 0);
    retire(ec, pc);
    check_outputs(ec, '0, 1'b0, 0);
    // Pulse lasts exactly one cycle and the count holds afterwards
    step();
    check_outputs(ec, '0, 1'b1, 1);
    step();
    check_outputs(ec, '0, 1'b0, 1);
    finish_test("ecall mismatch with save first", start_err);
  endtask

  task automatic test_priority();
    logic [PC_W-1:0]               pc;
    monitor_types_pkg::cause_vec_t mpu;
    monitor_types_pkg::cause_vec_t il;
    int unsigned                   start_err;
    start_err = errors;
    apply_reset();
    pc  = $urandom();
    mpu = slot_bit(trap_cause_pkg::SLOT_MPU);
    il  = slot_bit(trap_cause_pkg::SLOT_ILLEGAL);
    retire(mpu | il | slot_bit(trap_cause_pkg::SLOT_ECALL), pc);
    for (int unsigned s = 0; s < trap_cause_pkg::N_CAUSES; s++) begin
      save_cause(trap_cause_pkg::SLOT_CAUSE[s], pc);
    end
    check_outputs(mpu, mpu, 1'b0, 0);
    // A later illegal retirement at another PC closes that slot unmatched
    retire(il, pc + PC_W'(4));
    check_outputs(mpu | il, mpu, 1'b0, 0);
    step();
    check_outputs(mpu | il, mpu, 1'b1, 1);
    finish_test("cause priority within one retirement", start_err);
  endtask

  task automatic test_suppression();
    logic [PC_W-1:0]               pc;
    monitor_types_pkg::cause_vec_t il;
    monitor_types_pkg::cause_vec_t eb;
    int unsigned                   start_err;
    start_err = errors;
    apply_reset();
    pc = $urandom();
    il = slot_bit(trap_cause_pkg::SLOT_ILLEGAL);
    eb = slot_bit(trap_cause_pkg::SLOT_EBREAK);
    irq_ack = 1'b1;
    retire(il, pc + PC_W'(4));
    debug_req = 1'b1;
    retire(il, pc + PC_W'(8));
    nmi_pending = 1'b1;
    retire(il, pc + PC_W'(12));
    cause_interrupt = 1'b1;
    save_cause(trap_cause_pkg::CAUSE_ILLEGAL_INSN, pc + PC_W'(16));
    check_outputs('0, '0, 1'b0, 0);
    // First eligible pair decides, second strobes change nothing
    retire(il, pc);
    retire(il, pc + PC_W'(20));
    save_cause(trap_cause_pkg::CAUSE_ILLEGAL_INSN, pc);
    check_outputs(il, il, 1'b0, 0);
    save_cause(trap_cause_pkg::CAUSE_ILLEGAL_INSN, pc + PC_W'(24));
    // Debug entry drops an ECALL but still lets an EBREAK through
    debug_entry = 1'b1;
    retire(slot_bit(trap_cause_pkg::SLOT_ECALL), pc + PC_W'(28));
    debug_entry = 1'b1;
    retire(eb, pc + PC_W'(32));
    save_cause(trap_cause_pkg::CAUSE_ECALL_MMODE, pc + PC_W'(28));
    save_cause(trap_cause_pkg::CAUSE_BREAKPOINT, pc + PC_W'(32));
    step();
    check_outputs(il | eb, il | eb, 1'b0, 0);
    finish_test("suppression and first-only capture", start_err);
  endtask

  task automatic test_random_sweep();
    logic [PC_W-1:0]               pc;
    logic [PC_W-1:0]               mepc;
    monitor_types_pkg::cause_vec_t match_e;
    logic                          corrupt;
    logic                          act_first;
    int unsigned                   n_bad;
    int unsigned                   start_err;
    start_err = errors;
    apply_reset();
    match_e = '0;
    n_bad   = 0;
    for (int unsigned s = 0; s < trap_cause_pkg::N_CAUSES; s++) begin
      pc        = $urandom();
      corrupt   = ($urandom() % 2) == 1;
      act_first = ($urandom() % 2) == 1;
      // A corrupted mepc always differs from the PC in at least one bit
      mepc = corrupt ? pc ^ PC_W'($urandom() | 32'h1) : pc;
      if (corrupt) begin
        n_bad++;
      end else begin
        match_e[s] = 1'b1;
      end
      if (act_first) begin
        save_cause(trap_cause_pkg::SLOT_CAUSE[s], mepc);
        retire(slot_bit(s), pc);
      end else begin
        retire(slot_bit(s), pc);
        save_cause(trap_cause_pkg::SLOT_CAUSE[s], mepc);
      end
    end
    wait_done('1, 10);
    // Let the last pulse pass and the count settle
    step();
    step();
    check_outputs('1, match_e, 1'b0, (n_bad > MAX_ERR) ? MAX_ERR : n_bad);
    finish_test("random sweep over all causes", start_err);
  endtask

`endif

// ==== verif/tb_trap_mepc_monitor.sv ====
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the trap return address monitor
// Inputs change 1 time unit after the rising edge and outputs are read
// at that same point, so every read sees settled register values
// Runs with PC_W of 32; the run ends as a failure at the cycle limit
////////////////////////////////////////////////////////////////////////////

module tb_trap_mepc_monitor;

  localparam int unsigned PC_W        = 32;
  localparam int unsigned ERR_CNT_W   = 4;
  localparam int unsigned MAX_ERR     = (1 << ERR_CNT_W) - 1;
  // The whole sequence needs well under 200 cycles, this leaves a wide margin
  localparam int unsigned CYCLE_LIMIT = 2000;

  logic                          clk;
  logic                          rst_ni;
  logic                          retire_valid;
  logic [PC_W-1:0]               retire_pc;
  logic                          retire_illegal;
  logic                          retire_ecall;
  logic                          retire_ebreak;
  logic                          retire_bus_err;
  logic                          retire_mpu_err;
  logic                          irq_ack;
  logic                          debug_req;
  logic                          nmi_pending;
  logic                          debug_entry;
  logic                          csr_save_cause;
  logic                          cause_interrupt;
  trap_cause_pkg::cause_code_t   cause_code;
  logic [PC_W-1:0]               mepc_next;
  monitor_types_pkg::cause_vec_t cause_done;
  monitor_types_pkg::cause_vec_t cause_match;
  logic                          mismatch_pulse;
  logic [ERR_CNT_W-1:0]          error_count;

  int unsigned cycles = 0;
  int unsigned errors = 0;
  int unsigned tests_passed = 0;
  int unsigned tests_failed = 0;

  trap_mepc_monitor #(
    .PC_W      (PC_W),
    .ERR_CNT_W (ERR_CNT_W)
  ) dut_i (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Watchdog, stops a hung run
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout, the run went past %0d cycles", CYCLE_LIMIT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driver helpers
  ////////////////////////////////////////////////////////////////////////////

  // Advance to the drive point of the next cycle
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_inputs();
    retire_valid    = 1'b0;
    retire_pc       = '0;
    retire_illegal  = 1'b0;
    retire_ecall    = 1'b0;
    retire_ebreak   = 1'b0;
    retire_bus_err  = 1'b0;
    retire_mpu_err  = 1'b0;
    irq_ack         = 1'b0;
    debug_req       = 1'b0;
    nmi_pending     = 1'b0;
    debug_entry     = 1'b0;
    csr_save_cause  = 1'b0;
    cause_interrupt = 1'b0;
    cause_code      = '0;
    mepc_next       = '0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst_ni = 1'b0;
    clear_inputs();
    repeat (10) @(posedge clk);
    #1;
    rst_ni = 1'b1;
  endtask

  function automatic monitor_types_pkg::cause_vec_t slot_bit(input int unsigned slot);
    monitor_types_pkg::cause_vec_t v;
    v       = '0;
    v[slot] = 1'b1;
    return v;
  endfunction

  // One retirement cycle, flags are given in slot order
  // Suppression inputs set by the caller stay on for this cycle only
  task automatic retire(
    input monitor_types_pkg::cause_vec_t flags,
    input logic [PC_W-1:0]               pc
  );
    retire_valid   = 1'b1;
    retire_pc      = pc;
    retire_mpu_err = flags[trap_cause_pkg::SLOT_MPU];
    retire_bus_err = flags[trap_cause_pkg::SLOT_BUS];
    retire_illegal = flags[trap_cause_pkg::SLOT_ILLEGAL];
    retire_ecall   = flags[trap_cause_pkg::SLOT_ECALL];
    retire_ebreak  = flags[trap_cause_pkg::SLOT_EBREAK];
    step();
    clear_inputs();
  endtask

  // One cause save cycle
  task automatic save_cause(
    input trap_cause_pkg::cause_code_t code,
    input logic [PC_W-1:0]             mepc
  );
    csr_save_cause = 1'b1;
    cause_code     = code;
    mepc_next      = mepc;
    step();
    clear_inputs();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checking and reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(
    input string       name,
    input logic [31:0] exp_v,
    input logic [31:0] act_v
  );
    $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp_v, act_v);
    errors++;
  endtask

  task automatic check_outputs(
    input monitor_types_pkg::cause_vec_t done_e,
    input monitor_types_pkg::cause_vec_t match_e,
    input logic                          pulse_e,
    input int unsigned                   count_e
  );
    if (cause_done !== done_e) begin
      report_mismatch("cause_done", 32'(done_e), 32'(cause_done));
    end
    if (cause_match !== match_e) begin
      report_mismatch("cause_match", 32'(match_e), 32'(cause_match));
    end
    if (mismatch_pulse !== pulse_e) begin
      report_mismatch("mismatch_pulse", 32'(pulse_e), 32'(mismatch_pulse));
    end
    if (error_count !== ERR_CNT_W'(count_e)) begin
      report_mismatch("error_count", count_e, 32'(error_count));
    end
  endtask

  // Bounded wait until every slot in the mask has decided
  task automatic wait_done(input monitor_types_pkg::cause_vec_t mask, input int unsigned limit);
    int unsigned n;
    n = 0;
    while (((cause_done & mask) != mask) && (n < limit)) begin
      step();
      n++;
    end
    if ((cause_done & mask) != mask) begin
      $display("Slots 0x%0h gave no verdict within %0d cycles", mask, limit);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int unsigned start_err);
    if (errors == start_err) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d failed checks", name, errors - start_err);
    end
  endtask

  `include "tb_tests.svh"

  initial begin
    void'($urandom(32'he3bb));
    rst_ni = 1'b0;
    clear_inputs();
    test_after_reset();
    test_illegal_match();
    test_ecall_mismatch();
    test_priority();
    test_suppression();
    test_random_sweep();
    $display("Summary: %0d tests passed, %0d tests failed, %0d failed checks",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
source/trap_cause_pkg.sv
source/monitor_types_pkg.sv
source/trap_slot_if.sv
source/retire_classifier.sv
source/cause_slot.sv
source/verdict_collector.sv
source/trap_mepc_monitor.sv
+incdir+verif
verif/tb_trap_mepc_monitor.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_trap_mepc_monitor
RTL_TOP  = trap_mepc_monitor
FILELIST = list.f
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the testbench prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
